// File: src/rot_cfg.svh
`ifndef ROT_CFG_SVH
`define ROT_CFG_SVH

////////////////////////////////////////////////////////////
// sprite geometry
////////////////////////////////////////////////////////////

`define IMAGE_SIZE  32   // sprite edge in pixels, a power of two.
`define COOR_WIDTH  5    // bits of one pixel coordinate.
`define COLOR_WIDTH 8    // colour code width, code 0 is transparent.

////////////////////////////////////////////////////////////
// rotation
////////////////////////////////////////////////////////////

// angles are signed binary angle units, one unit is 1/512 of a turn.
`define ANG_WIDTH   9

`define ROT_STAGES  8    // cordic micro-rotation stages.
`define CORDIC_FRAC 6    // fraction bits of the rotator datapath.

`endif

// File: src/rot_pkg.sv
`include "rot_cfg.svh"

package rot_pkg;

    typedef logic [`COOR_WIDTH-1:0] coor_t;          // unsigned pixel coordinate.
    typedef logic [`COLOR_WIDTH-1:0] color_t;        // colour code, zero is transparent.
    typedef logic signed [`ANG_WIDTH-1:0] angle_t;   // 1/512 turn per unit.

    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_START = 1'b1
    } cmd_op_e;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_RUN  = 1'b1
    } ctl_state_e;

    typedef struct packed {
        cmd_op_e op;
        coor_t   h;
        coor_t   v;
        color_t  color;     // used by OP_WRITE only.
        angle_t  angle;     // used by OP_START only.
    } rot_cmd_t;

    typedef struct packed {
        coor_t  dst_h;
        coor_t  dst_v;
        coor_t  src_h;
        coor_t  src_v;
        color_t color;
        logic   opaque;
        logic   out_of_range;
    } pix_out_t;

    typedef struct packed {
        logic   en;
        coor_t  h;
        coor_t  v;
        color_t color;
    } sprite_wr_t;

endpackage

// File: src/rot_regs.sv
`timescale 1ns/1ns

module rot_regs (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  rot_pkg::rot_cmd_t   i_cmd,
    input  logic                i_cmd_valid,
    output logic                o_cmd_ready,
    output rot_pkg::sprite_wr_t o_sprite_wr,
    output rot_pkg::angle_t     o_angle,
    output logic                o_start,
    input  logic                i_frame_done,
    output logic                o_busy
);

    rot_pkg::ctl_state_e state_r;
    rot_pkg::angle_t     angle_r;
    logic                start_r;
    logic                cmd_fire;
    logic                start_fire;

    assign o_cmd_ready = (state_r == rot_pkg::ST_IDLE);   // commands wait while a frame runs.
    assign cmd_fire    = i_cmd_valid && o_cmd_ready;
    assign start_fire  = cmd_fire && (i_cmd.op == rot_pkg::OP_START);

    // the write strobe reaches the memory in the same cycle as the command.
    always_comb begin
        o_sprite_wr.en    = cmd_fire && (i_cmd.op == rot_pkg::OP_WRITE);
        o_sprite_wr.h     = i_cmd.h;
        o_sprite_wr.v     = i_cmd.v;
        o_sprite_wr.color = i_cmd.color;
    end

    ////////////////////////////////////////////////////////////
    // control fsm
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r <= rot_pkg::ST_IDLE;
            start_r <= 1'b0;
            angle_r <= '0;
        end else begin
            start_r <= start_fire;                 // one cycle pulse after the accept.
            if (start_fire) begin
                angle_r <= i_cmd.angle;
            end
            case (state_r)
                rot_pkg::ST_IDLE: if (start_fire) state_r <= rot_pkg::ST_RUN;
                rot_pkg::ST_RUN:  if (i_frame_done) state_r <= rot_pkg::ST_IDLE;
                default:          state_r <= rot_pkg::ST_IDLE;
            endcase
        end
    end

    assign o_start = start_r;
    assign o_angle = angle_r;
    assign o_busy  = (state_r == rot_pkg::ST_RUN);

endmodule

// File: src/sprite_mem.sv
`timescale 1ns/1ns
`include "rot_cfg.svh"

module sprite_mem (
    input  logic                i_clk,
    input  rot_pkg::sprite_wr_t i_sprite_wr,
    input  logic                i_en,
    input  rot_pkg::coor_t      i_rd_h,
    input  rot_pkg::coor_t      i_rd_v,
    output rot_pkg::color_t     o_rd_color
);

    localparam int DEPTH = `IMAGE_SIZE * `IMAGE_SIZE;
    localparam int AW    = 2 * `COOR_WIDTH;

    rot_pkg::color_t mem [0:DEPTH-1];
    logic [AW-1:0]   wr_addr;
    logic [AW-1:0]   rd_addr;

    // row major, v selects the row and h the column.
    assign wr_addr = {i_sprite_wr.v, i_sprite_wr.h};
    assign rd_addr = {i_rd_v, i_rd_h};

    ////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_sprite_wr.en) begin
            mem[wr_addr] <= i_sprite_wr.color;
        end
    end

    ////////////////////////////////////////////////////////////
    // read port
    ////////////////////////////////////////////////////////////

    // data follows the address by one enabled cycle and holds on a stall.
    always_ff @(posedge i_clk) begin
        if (i_en) begin
            o_rd_color <= mem[rd_addr];
        end
    end

endmodule

// File: src/coor_rotator.sv
`timescale 1ns/1ns
`include "rot_cfg.svh"

module coor_rotator (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_en,
    input  logic            i_valid,
    input  rot_pkg::coor_t  i_h,
    input  rot_pkg::coor_t  i_v,
    input  rot_pkg::angle_t i_angle,
    output logic            o_valid,
    output rot_pkg::coor_t  o_h,
    output rot_pkg::coor_t  o_v,
    output rot_pkg::coor_t  o_dst_h,
    output rot_pkg::coor_t  o_dst_v,
    output logic            o_out_of_range
);

    localparam int XW         = `COOR_WIDTH + `CORDIC_FRAC + 3;
    localparam int ATAN_FRAC  = 4;                  // extra angle bits inside the cordic.
    localparam int ZW         = `ANG_WIDTH + ATAN_FRAC;
    localparam int PW         = XW + 12;
    localparam int GAIN_SHIFT = 10;
    localparam logic signed [11:0] GAIN_INV = 12'sd622;   // 1/K of 8 stages scaled by 1024.
    localparam logic [`ANG_WIDTH-1:0] QTR = 1 << (`ANG_WIDTH - 3);   // half a quadrant.

    function automatic logic signed [ZW-1:0] atan_lut(input int k);
        case (k)
            0:       atan_lut = ZW'(1024);
            1:       atan_lut = ZW'(605);
            2:       atan_lut = ZW'(319);
            3:       atan_lut = ZW'(162);
            4:       atan_lut = ZW'(81);
            5:       atan_lut = ZW'(41);
            6:       atan_lut = ZW'(20);
            default: atan_lut = ZW'(10);
        endcase
    endfunction

    logic [`ANG_WIDTH-1:0]        ang_adj;
    logic [1:0]                   quad;
    logic signed [`ANG_WIDTH-2:0] resid;
    logic signed [ZW-1:0]         z0;
    logic signed [XW-1:0]         cx, cy, qx, qy;
    logic signed [PW-1:0]         px, py, sx, sy;

    logic [`ROT_STAGES:0] vld_r;
    logic signed [XW-1:0] x_r [0:`ROT_STAGES];
    logic signed [XW-1:0] y_r [0:`ROT_STAGES];
    logic signed [ZW-1:0] z_r [0:`ROT_STAGES-1];
    rot_pkg::coor_t       dh_r [0:`ROT_STAGES];
    rot_pkg::coor_t       dv_r [0:`ROT_STAGES];

    ////////////////////////////////////////////////////////////
    // centring and quadrant swap
    ////////////////////////////////////////////////////////////

    always_comb begin
        ang_adj = i_angle + QTR;                   // rounds to the nearest quadrant.
        quad    = ang_adj[`ANG_WIDTH-1 -: 2];
        resid   = {1'b0, ang_adj[`ANG_WIDTH-3:0]} - QTR[`ANG_WIDTH-2:0];
        z0      = ZW'(resid) <<< ATAN_FRAC;
        cx = (XW'({i_h, 1'b0}) - XW'(`IMAGE_SIZE - 1)) <<< (`CORDIC_FRAC - 1);
        cy = (XW'({i_v, 1'b0}) - XW'(`IMAGE_SIZE - 1)) <<< (`CORDIC_FRAC - 1);
        case (quad)
            2'd0: begin
                qx = cx;
                qy = cy;
            end
            2'd1: begin
                qx = -cy;
                qy = cx;
            end
            2'd2: begin
                qx = -cx;
                qy = -cy;
            end
            default: begin
                qx = cy;
                qy = -cx;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // gain and range
    ////////////////////////////////////////////////////////////

    always_comb begin
        px = PW'(x_r[`ROT_STAGES]) * PW'(GAIN_INV);
        py = PW'(y_r[`ROT_STAGES]) * PW'(GAIN_INV);
        // floor(x + 16) rounds x + 15.5.
        sx = (px >>> (GAIN_SHIFT + `CORDIC_FRAC)) + PW'(`IMAGE_SIZE / 2);
        sy = (py >>> (GAIN_SHIFT + `CORDIC_FRAC)) + PW'(`IMAGE_SIZE / 2);
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            vld_r   <= '0;
            o_valid <= 1'b0;
        end else if (i_en) begin
            vld_r   <= {vld_r[`ROT_STAGES-1:0], i_valid};
            o_valid <= vld_r[`ROT_STAGES];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_en) begin
            x_r[0]  <= qx;
            y_r[0]  <= qy;
            z_r[0]  <= z0;
            dh_r[0] <= i_h;
            dv_r[0] <= i_v;
            for (int k = 0; k < `ROT_STAGES; k++) begin
                if (z_r[k][ZW-1]) begin
                    x_r[k+1] <= x_r[k] + (y_r[k] >>> k);
                    y_r[k+1] <= y_r[k] - (x_r[k] >>> k);
                end else begin
                    x_r[k+1] <= x_r[k] - (y_r[k] >>> k);
                    y_r[k+1] <= y_r[k] + (x_r[k] >>> k);
                end
                dh_r[k+1] <= dh_r[k];
                dv_r[k+1] <= dv_r[k];
            end
            for (int k = 0; k < `ROT_STAGES - 1; k++) begin
                z_r[k+1] <= z_r[k][ZW-1] ? z_r[k] + atan_lut(k) : z_r[k] - atan_lut(k);
            end
            o_h            <= sx[`COOR_WIDTH-1:0];
            o_v            <= sy[`COOR_WIDTH-1:0];
            o_dst_h        <= dh_r[`ROT_STAGES];
            o_dst_v        <= dv_r[`ROT_STAGES];
            // any high bit is off the sprite.
            o_out_of_range <= (|sx[PW-1:`COOR_WIDTH]) | (|sy[PW-1:`COOR_WIDTH]);
        end
    end

endmodule

// File: src/image_rotator.sv
`timescale 1ns/1ns
`include "rot_cfg.svh"

module image_rotator (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_start,
    input  rot_pkg::angle_t     i_angle,
    input  rot_pkg::sprite_wr_t i_sprite_wr,
    output rot_pkg::pix_out_t   o_pix,
    output logic                o_pix_valid,
    input  logic                i_pix_ready,
    output logic                o_frame_done
);

    localparam rot_pkg::coor_t COOR_MAX = `COOR_WIDTH'(`IMAGE_SIZE - 1);

    logic            pipe_en;
    logic            scan_run_r;
    logic            scan_valid;
    logic            scan_last;
    rot_pkg::coor_t  scan_h_r, scan_v_r;
    rot_pkg::angle_t neg_angle;

    logic            rot_valid;
    rot_pkg::coor_t  rot_h, rot_v, rot_dst_h, rot_dst_v;
    logic            rot_oor;
    rot_pkg::color_t mem_color;
    rot_pkg::color_t pix_color;

    logic            pix_valid_r;
    rot_pkg::coor_t  dst_h_r, dst_v_r, src_h_r, src_v_r;
    logic            oor_r;

    assign pipe_en = !pix_valid_r || i_pix_ready;   // the whole pipe stalls on back-pressure.

    ////////////////////////////////////////////////////////////
    // raster scan
    ////////////////////////////////////////////////////////////

    assign scan_valid = i_start || scan_run_r;     // pixel 0 issues in the start cycle.
    assign scan_last  = (scan_h_r == COOR_MAX) && (scan_v_r == COOR_MAX);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            scan_run_r <= 1'b0;
            scan_h_r   <= '0;
            scan_v_r   <= '0;
        end else if (pipe_en && scan_valid) begin
            scan_run_r <= !scan_last;
            if (scan_h_r == COOR_MAX) begin
                scan_h_r <= '0;
                scan_v_r <= scan_last ? '0 : scan_v_r + 1'b1;
            end else begin
                scan_h_r <= scan_h_r + 1'b1;
            end
        end else if (i_start) begin
            scan_run_r <= 1'b1;
        end
    end

    assign neg_angle = -i_angle;                   // inverse mapping from destination to source.

    coor_rotator u_coor_rotator (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_en           (pipe_en),
        .i_valid        (scan_valid),
        .i_h            (scan_h_r),
        .i_v            (scan_v_r),
        .i_angle        (neg_angle),
        .o_valid        (rot_valid),
        .o_h            (rot_h),
        .o_v            (rot_v),
        .o_dst_h        (rot_dst_h),
        .o_dst_v        (rot_dst_v),
        .o_out_of_range (rot_oor)
    );

    sprite_mem u_sprite_mem (
        .i_clk       (i_clk),
        .i_sprite_wr (i_sprite_wr),
        .i_en        (pipe_en),
        .i_rd_h      (rot_h),
        .i_rd_v      (rot_v),
        .o_rd_color  (mem_color)
    );

    ////////////////////////////////////////////////////////////
    // output stage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pix_valid_r <= 1'b0;
        end else if (pipe_en) begin
            pix_valid_r <= rot_valid;
        end
    end

    // sideband registers line up with the memory read.
    always_ff @(posedge i_clk) begin
        if (pipe_en) begin
            dst_h_r <= rot_dst_h;
            dst_v_r <= rot_dst_v;
            src_h_r <= rot_h;
            src_v_r <= rot_v;
            oor_r   <= rot_oor;
        end
    end

    assign pix_color = oor_r ? '0 : mem_color;

    always_comb begin
        o_pix.dst_h        = dst_h_r;
        o_pix.dst_v        = dst_v_r;
        o_pix.src_h        = src_h_r;
        o_pix.src_v        = src_v_r;
        o_pix.color        = pix_color;
        o_pix.opaque       = (pix_color != '0);
        o_pix.out_of_range = oor_r;
    end

    assign o_pix_valid  = pix_valid_r;
    assign o_frame_done = pix_valid_r && i_pix_ready && (dst_h_r == COOR_MAX) && (dst_v_r == COOR_MAX);

endmodule

// File: src/rot_top.sv
`timescale 1ns/1ns

module rot_top (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  rot_pkg::rot_cmd_t i_cmd,
    input  logic              i_cmd_valid,
    output logic              o_cmd_ready,
    output rot_pkg::pix_out_t o_pix,
    output logic              o_pix_valid,
    input  logic              i_pix_ready,
    output logic              o_busy
);

    rot_pkg::sprite_wr_t sprite_wr;
    rot_pkg::angle_t     angle;
    logic                start;
    logic                frame_done;

    ////////////////////////////////////////////////////////////
    // host side
    ////////////////////////////////////////////////////////////

    rot_regs u_rot_regs (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_cmd        (i_cmd),
        .i_cmd_valid  (i_cmd_valid),
        .o_cmd_ready  (o_cmd_ready),
        .o_sprite_wr  (sprite_wr),
        .o_angle      (angle),
        .o_start      (start),
        .i_frame_done (frame_done),
        .o_busy       (o_busy)
    );

    ////////////////////////////////////////////////////////////
    // pixel side
    ////////////////////////////////////////////////////////////

    image_rotator u_image_rotator (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (start),
        .i_angle      (angle),
        .i_sprite_wr  (sprite_wr),
        .o_pix        (o_pix),
        .o_pix_valid  (o_pix_valid),
        .i_pix_ready  (i_pix_ready),
        .o_frame_done (frame_done)
    );

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic o_clk
);

    localparam int HALF_PERIOD = 2;   // 4 ns period.

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

endmodule

// File: tb/rot_sva.sv
`timescale 1ns/1ns
`include "rot_cfg.svh"

module rot_sva (
    input logic              i_clk,
    input logic              i_rst_n,
    input logic              i_cmd_ready,
    input rot_pkg::pix_out_t i_pix,
    input logic              i_pix_valid,
    input logic              i_pix_ready,
    input logic              i_busy
);

    localparam int FRAME_PIX = `IMAGE_SIZE * `IMAGE_SIZE;

    int                       fail_count = 0;
    logic                     xfer;
    logic [2*`COOR_WIDTH-1:0] next_pos;      // raster position of the next transfer.
    logic [2*`COOR_WIDTH:0]   frame_xfers;

    assign xfer = i_pix_valid && i_pix_ready;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            next_pos    <= '0;
            frame_xfers <= '0;
        end else begin
            if (xfer) begin
                next_pos <= next_pos + 1'b1;         // wraps into the next frame.
            end
            if (!i_busy) begin
                frame_xfers <= '0;
            end else if (xfer) begin
                frame_xfers <= frame_xfers + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // handshakes
    ////////////////////////////////////////////////////////////

    reset_idle: assert property (@(posedge i_clk)
        !i_rst_n |=> (!i_pix_valid && !i_busy && i_cmd_ready))
        else begin $error("error %0t: outputs not idle after reset", $time); fail_count++; end

    busy_blocks_cmd: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_busy |-> !i_cmd_ready)
        else begin $error("error %0t: command port ready while busy", $time); fail_count++; end

    pix_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_pix_valid && !i_pix_ready) |=> (i_pix_valid && $stable(i_pix)))
        else begin $error("error %0t: pixel changed while stalled", $time); fail_count++; end

    ////////////////////////////////////////////////////////////
    // pixel stream
    ////////////////////////////////////////////////////////////

    opaque_flag: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_pix_valid |-> (i_pix.opaque == (i_pix.color != '0)))
        else begin $error("error %0t: opaque flag disagrees with colour", $time); fail_count++; end

    oor_clear: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_pix_valid && i_pix.out_of_range) |-> (i_pix.color == '0))
        else begin $error("error %0t: out of range pixel has colour", $time); fail_count++; end

    raster_order: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        xfer |-> ({i_pix.dst_v, i_pix.dst_h} == next_pos))
        else begin $error("error %0t: destination out of raster order", $time); fail_count++; end

    frame_length: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $fell(i_busy) |-> (frame_xfers == FRAME_PIX))
        else begin $error("error %0t: busy fell after wrong pixel count", $time); fail_count++; end

endmodule

bind rot_top rot_sva u_rot_sva (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_cmd_ready (o_cmd_ready),
    .i_pix       (o_pix),
    .i_pix_valid (o_pix_valid),
    .i_pix_ready (i_pix_ready),
    .i_busy      (o_busy)
);

// File: tb/tb_rot.sv
`timescale 1ns/1ns
`include "rot_cfg.svh"

module tb_rot;

    localparam int  FRAME_PIX   = `IMAGE_SIZE * `IMAGE_SIZE;
    localparam int  NUM_FRAMES  = 4;
    localparam int  NUM_REWRITE = 64;
    // stalled frames run at most twice as long and the sprite load takes one cycle per pixel.
    localparam int  CYCLE_LIMIT = NUM_FRAMES * FRAME_PIX * 2 + FRAME_PIX + NUM_REWRITE + 2000;
    localparam real CENTRE      = (`IMAGE_SIZE - 1) / 2.0;
    localparam real PI          = 3.14159265358979;

    logic              clk;
    logic              rst_n;
    rot_pkg::rot_cmd_t cmd;
    logic              cmd_valid;
    logic              cmd_ready;
    rot_pkg::pix_out_t pix;
    logic              pix_valid;
    logic              pix_ready;
    logic              busy;

    logic [31:0]       lcg_state = 32'd58990;
    rot_pkg::color_t   sprite_ref [0:FRAME_PIX-1];   // host view of the sprite memory.
    rot_pkg::angle_t   frame_angle;
    logic              stall_on;
    int                pix_count = 0;
    int                tb_errors = 0;
    int                cycles = 0;
    int                tests_run = 0;
    int                tests_failed = 0;

    tb_clock u_clock (.o_clk(clk));

    rot_top dut0 (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_cmd       (cmd),
        .i_cmd_valid (cmd_valid),
        .o_cmd_ready (cmd_ready),
        .o_pix       (pix),
        .o_pix_valid (pix_valid),
        .i_pix_ready (pix_ready),
        .o_busy      (busy)
    );

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic rot_pkg::color_t random_color();
        logic [31:0] r;
        r = next_rand();
        if (r[31:30] == 2'b00) begin
            return '0;                                   // about a quarter transparent.
        end
        return (r[23:16] == '0) ? `COLOR_WIDTH'(1) : r[23:16];
    endfunction

    function automatic logic ready_draw();
        logic [31:0] r;
        r = next_rand();
        return r[31:30] != 2'b00;
    endfunction

    function automatic real abs_diff(input real a, input real b);
        return (a > b) ? a - b : b - a;
    endfunction

    function automatic int error_total();
        return tb_errors + dut0.u_rot_sva.fail_count;
    endfunction

    task automatic report_test(input string name, input int errs_before);
        int n;
        n = error_total() - errs_before;
        tests_run++;
        if (n != 0) begin
            tests_failed++;
        end
        $display("test %s %s, %0d errors", name, (n == 0) ? "ok" : "FAILED", n);
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic send_cmd(input rot_pkg::cmd_op_e op, input rot_pkg::coor_t h,
                            input rot_pkg::coor_t v, input rot_pkg::color_t color,
                            input rot_pkg::angle_t angle);
        cmd.op    = op;
        cmd.h     = h;
        cmd.v     = v;
        cmd.color = color;
        cmd.angle = angle;
        cmd_valid = 1'b1;
        while (!cmd_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic write_pixel(input rot_pkg::coor_t h, input rot_pkg::coor_t v,
                               input rot_pkg::color_t color);
        send_cmd(rot_pkg::OP_WRITE, h, v, color, '0);
        sprite_ref[{v, h}] = color;
    endtask

    task automatic check_reset();
        int errs_before;
        errs_before = error_total();
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert (!pix_valid && !busy && cmd_ready) else begin
            $display("error %0t: ports not idle after reset", $time);
            tb_errors++;
        end
        report_test("reset", errs_before);
    endtask

    task automatic run_frame(input string name, input rot_pkg::angle_t angle, input logic stall);
        int errs_before;
        errs_before = error_total();
        frame_angle = angle;
        stall_on    = stall;
        pix_count   = 0;
        send_cmd(rot_pkg::OP_START, '0, '0, '0, angle);
        while (busy) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);                                // lets the end-of-frame assertion fire.
        #1;
        stall_on = 1'b0;
        assert (pix_count == FRAME_PIX) else begin
            $display("error %0t: frame moved %0d pixels", $time, pix_count);
            tb_errors++;
        end
        report_test(name, errs_before);
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    task automatic check_pixel(input rot_pkg::pix_out_t p);
        real             th;
        real             x;
        real             y;
        real             rx;
        real             ry;
        logic            interior;
        logic            outside;
        rot_pkg::color_t exp_color;
        th = -2.0 * PI * real'(int'(frame_angle)) / real'(1 << `ANG_WIDTH);
        x  = real'(p.dst_h) - CENTRE;
        y  = real'(p.dst_v) - CENTRE;
        rx = x * $cos(th) - y * $sin(th) + CENTRE;
        ry = x * $sin(th) + y * $cos(th) + CENTRE;
        interior = rx > 0.5 && rx < 2.0 * CENTRE - 0.5 && ry > 0.5 && ry < 2.0 * CENTRE - 0.5;
        outside  = rx < -1.5 || rx > 2.0 * CENTRE + 1.5 || ry < -1.5 || ry > 2.0 * CENTRE + 1.5;
        if (!p.out_of_range) begin
            assert (abs_diff(real'(p.src_h), rx) <= 1.0 && abs_diff(real'(p.src_v), ry) <= 1.0)
            else begin
                $display("error %0t: dst (%0d,%0d) src (%0d,%0d) expected near (%.2f,%.2f)",
                         $time, p.dst_h, p.dst_v, p.src_h, p.src_v, rx, ry);
                tb_errors++;
            end
        end
        assert (!(interior && p.out_of_range) && !(outside && !p.out_of_range)) else begin
            $display("error %0t: dst (%0d,%0d) range flag %0b, reference (%.2f,%.2f)",
                     $time, p.dst_h, p.dst_v, p.out_of_range, rx, ry);
            tb_errors++;
        end
        assert (frame_angle != '0 || !p.out_of_range) else begin
            $display("error %0t: dst (%0d,%0d) out of range at angle 0",
                     $time, p.dst_h, p.dst_v);
            tb_errors++;
        end
        exp_color = p.out_of_range ? '0 : sprite_ref[{p.src_v, p.src_h}];
        assert (p.color == exp_color) else begin
            $display("error %0t: dst (%0d,%0d) colour %0h, expected %0h",
                     $time, p.dst_h, p.dst_v, p.color, exp_color);
            tb_errors++;
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && pix_valid && pix_ready) begin     // a transfer happens at the next edge.
            check_pixel(pix);
            pix_count++;
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            #1;
            pix_ready = stall_on ? ready_draw() : 1'b1;
        end
    end

    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", cycles);
        $display("Done: errors found");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst_n       = 1'b0;
        cmd         = '0;
        cmd_valid   = 1'b0;
        pix_ready   = 1'b1;
        stall_on    = 1'b0;
        frame_angle = '0;
        check_reset();
        for (int i = 0; i < FRAME_PIX; i++) begin
            write_pixel(rot_pkg::coor_t'(i), rot_pkg::coor_t'(i >> `COOR_WIDTH), random_color());
        end
        run_frame("angle_0", '0, 1'b0);
        run_frame("angle_37_stall", `ANG_WIDTH'(37), 1'b1);
        for (int i = 0; i < NUM_REWRITE; i++) begin
            write_pixel(rot_pkg::coor_t'(next_rand() >> 27), rot_pkg::coor_t'(next_rand() >> 27),
                        random_color());            // the next frame must show these.
        end
        run_frame("angle_200_rewrite", `ANG_WIDTH'(200), 1'b1);
        run_frame("angle_minus_150", `ANG_WIDTH'(-150), 1'b1);
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_total());
        if (error_total() == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+src
src/rot_pkg.sv
src/rot_regs.sv
src/sprite_mem.sv
src/coor_rotator.sv
src/image_rotator.sv
src/rot_top.sv
tb/tb_clock.sv
tb/rot_sva.sv
tb/tb_rot.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

verilator --binary --timing --assert -f vlog.f --top-module tb_rot -o sim_rot

# assertion failures are counted by the testbench, so the run must not stop at the first one
./obj_dir/sim_rot +verilator+error+limit+10000 | tee sim.log

if grep -q "Done: errors found" sim.log; then
    exit 1
fi
exit 0
